//--- dz_show.f
source/dz_pkg.sv
source/dz_regs.sv
source/dz_countdown.sv
source/dz_glyph_rom.sv
source/dz_scan.sv
source/dz_show_top.sv
tb/tb_dz_show.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dz_show \
    -f dz_show.f \
    -o tb_dz_show
./obj_dir/tb_dz_show

//--- source/dz_countdown.sv
`timescale 1ns/1ps

module dz_countdown #(
    parameter int TICK_DIV = 1000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [2:0]         load_digit,
    output dz_pkg::dz_status_t status
);
    import dz_pkg::*;

    localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [TW-1:0] tick;
    logic          tick_wrap;
    logic [2:0]    digit;
    logic          running;
    logic          done;

    assign tick_wrap = (tick == TW'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick    <= '0;
            digit   <= 3'd0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (start)
        begin
            // a start while running simply reloads
            tick    <= '0;
            digit   <= load_digit;
            running <= (load_digit != 3'd0);
            done    <= (load_digit == 3'd0);
        end
        else if (running)
        begin
            if (tick_wrap)
            begin
                tick  <= '0;
                digit <= digit - 3'd1;
                if (digit == 3'd1)
                begin
                    running <= 1'b0;
                    done    <= 1'b1;  // held until next start
                end
            end
            else
                tick <= tick + 1'b1;
        end
    end

    assign status.digit   = digit;
    assign status.running = running;
    assign status.done    = done;

    // load range is enforced by the register block
    digit_range: assert property (@(posedge clk) disable iff (rst)
        status.digit <= dz_digit_max);

endmodule

//--- source/dz_glyph_rom.sv
`timescale 1ns/1ps

module dz_glyph_rom (
    input  logic [2:0] digit,
    input  logic [2:0] row_idx,
    output logic [7:0] red_bits,
    output logic [7:0] green_bits
);
    import dz_pkg::*;

    logic [7:0] pattern;
    dz_color_e  color;

    always_comb
    begin
        pattern = 8'h00;    // row 7 and bad digits stay dark
        case (digit)
            3'd5:
                case (row_idx)
                    3'd0:       pattern = 8'b0111_1110;
                    3'd1:       pattern = 8'b0110_0000;
                    3'd2:       pattern = 8'b0111_1100;
                    3'd3, 3'd4: pattern = 8'b0000_0110;
                    3'd5:       pattern = 8'b0110_0110;
                    3'd6:       pattern = 8'b0011_1100;
                    default:    pattern = 8'h00;
                endcase
            3'd4:
                case (row_idx)
                    3'd0, 3'd5, 3'd6: pattern = 8'b0000_1100;
                    3'd1:             pattern = 8'b0001_1100;
                    3'd2:             pattern = 8'b0010_1100;
                    3'd3:             pattern = 8'b0100_1100;
                    3'd4:             pattern = 8'b0111_1110;
                    default:          pattern = 8'h00;
                endcase
            3'd3, 3'd2:
                case (row_idx)
                    3'd0:    pattern = 8'b0011_1100;
                    3'd1:    pattern = 8'b0110_0110;
                    3'd2:    pattern = 8'b0000_0110;
                    3'd3:    pattern = (digit == 3'd3) ? 8'b0001_1100 : 8'b0000_1100;
                    3'd4:    pattern = (digit == 3'd3) ? 8'b0000_0110 : 8'b0011_0000;
                    3'd5:    pattern = (digit == 3'd3) ? 8'b0110_0110 : 8'b0110_0000;
                    3'd6:    pattern = (digit == 3'd3) ? 8'b0011_1100 : 8'b0111_1110;
                    default: pattern = 8'h00;
                endcase
            3'd1:
                case (row_idx)
                    3'd2:    pattern = 8'b0011_1000;
                    3'd6:    pattern = 8'b0111_1110;
                    3'd7:    pattern = 8'h00;
                    default: pattern = 8'b0001_1000;
                endcase
            3'd0:
                case (row_idx)
                    3'd0, 3'd6: pattern = 8'b0011_1100;
                    3'd7:       pattern = 8'h00;
                    default:    pattern = 8'b0100_0010;
                endcase
            default: pattern = 8'h00;
        endcase
    end

    // colour goes red -> yellow -> green as the count runs out
    always_comb
    begin
        case (digit)
            3'd5, 3'd4: color = red;
            3'd3, 3'd2: color = yellow;
            default:    color = green;
        endcase
    end

    assign red_bits   = (color == red || color == yellow) ? pattern : 8'h00;
    assign green_bits = (color == green || color == yellow) ? pattern : 8'h00;

endmodule

//--- source/dz_pkg.sv
package dz_pkg;

    localparam logic [2:0] dz_digit_max = 3'd5;

    // register byte offsets
    localparam logic [3:0] dz_addr_ctrl   = 4'h0;
    localparam logic [3:0] dz_addr_load   = 4'h4;
    localparam logic [3:0] dz_addr_status = 4'h8;

    localparam logic [1:0] axil_okay   = 2'b00;
    localparam logic [1:0] axil_slverr = 2'b10;

    typedef enum logic [1:0] {
        red    = 2'd0,
        green  = 2'd1,
        yellow = 2'd2   // both column sets lit
    } dz_color_e;

    // master to slave
    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [2:0] digit;
        logic       running;
        logic       done;
    } dz_status_t;

endpackage

//--- source/dz_regs.sv
`timescale 1ns/1ps

module dz_regs (
    input  logic               clk,
    input  logic               rst,
    input  dz_pkg::axil_req_t  axil_req,
    output dz_pkg::axil_rsp_t  axil_rsp,
    input  dz_pkg::dz_status_t status,
    output logic               start,
    output logic [2:0]         load_digit
);
    import dz_pkg::*;

    typedef enum logic {wr_idle, wr_resp} wr_state_e;
    typedef enum logic {rd_idle, rd_resp} rd_state_e;

    wr_state_e   wr_state;
    rd_state_e   rd_state;
    logic        wr_ready;    // awready and wready together
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rd_ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [2:0]  load_q;
    logic        wr_err;

    always_comb
    begin
        case (axil_req.awaddr)
            dz_addr_ctrl, dz_addr_status: wr_err = 1'b0;
            dz_addr_load:                 wr_err = axil_req.wdata > 32'(dz_digit_max);
            default:                      wr_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_state <= wr_idle;
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            start    <= 1'b0;
            load_q   <= 3'd0;
        end
        else
        begin
            start <= 1'b0;
            case (wr_state)
                wr_idle:
                    if (wr_ready)
                    begin
                        // handshake completes this cycle
                        wr_ready <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= wr_resp;
                        if (!wr_err && axil_req.wstrb[0])
                        begin
                            if (axil_req.awaddr == dz_addr_load)
                                load_q <= axil_req.wdata[2:0];
                            if (axil_req.awaddr == dz_addr_ctrl && axil_req.wdata[0])
                                start <= 1'b1;
                        end
                    end
                    else if (axil_req.awvalid && axil_req.wvalid)
                        wr_ready <= 1'b1;
                wr_resp:
                    if (axil_req.bready)
                    begin
                        bvalid   <= 1'b0;
                        wr_state <= wr_idle;
                    end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_state <= rd_idle;
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end
        else
        begin
            case (rd_state)
                rd_idle:
                    if (rd_ready)
                    begin
                        rd_ready <= 1'b0;
                        rvalid   <= 1'b1;
                        rd_state <= rd_resp;
                    end
                    else if (axil_req.arvalid)
                        rd_ready <= 1'b1;
                rd_resp:
                    if (axil_req.rready)
                    begin
                        rvalid   <= 1'b0;
                        rd_state <= rd_idle;
                    end
            endcase
        end
    end

    // response payload
    always_ff @(posedge clk)
    begin
        if (wr_state == wr_idle && wr_ready)
            bresp <= wr_err ? axil_slverr : axil_okay;
        if (rd_state == rd_idle && rd_ready)
        begin
            rresp <= axil_okay;
            case (axil_req.araddr)
                dz_addr_ctrl:   rdata <= 32'd0;
                dz_addr_load:   rdata <= {29'd0, load_q};
                dz_addr_status: rdata <= {26'd0, status.done, status.running, 1'b0, status.digit};
                default:
                begin
                    rdata <= 32'd0;
                    rresp <= axil_slverr;
                end
            endcase
        end
    end

    assign axil_rsp.awready = wr_ready;
    assign axil_rsp.wready  = wr_ready;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.bresp   = bresp;
    assign axil_rsp.arready = rd_ready;
    assign axil_rsp.rvalid  = rvalid;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = rresp;
    assign load_digit       = load_q;

    // write response must wait for the host
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

endmodule

//--- source/dz_scan.sv
`timescale 1ns/1ps

module dz_scan (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] digit,
    output logic [2:0] row_idx,
    input  logic [7:0] red_bits,
    input  logic [7:0] green_bits,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);
    import dz_pkg::*;

    logic [2:0] row_cnt;
    logic [2:0] digit_q;
    logic       digit_ok;

    assign row_idx  = row_cnt;   // feeds the glyph lookup
    assign digit_ok = (digit_q <= dz_digit_max);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= 3'd0;
            digit_q <= 3'd0;
            row     <= 8'hff;    // no row selected
            colr    <= 8'h00;
            colg    <= 8'h00;
        end
        else
        begin
            row_cnt <= row_cnt + 3'd1;   // wraps 7 -> 0
            digit_q <= digit;
            row     <= ~(8'd1 << row_cnt);
            if (digit_ok)
            begin
                colr <= red_bits;
                colg <= green_bits;
            end
            else
            begin
                // blank on a corrupt digit
                colr <= 8'h00;
                colg <= 8'h00;
            end
        end
    end

    one_row: assert property (@(posedge clk) disable iff (rst)
        $countones(~row) <= 1);

endmodule

//--- source/dz_show_top.sv
`timescale 1ns/1ps

module dz_show_top #(
    parameter int TICK_DIV = 1000
) (
    input  logic              clk,
    input  logic              rst,
    input  dz_pkg::axil_req_t axil_req,
    output dz_pkg::axil_rsp_t axil_rsp,
    output logic [7:0]        row,
    output logic [7:0]        colr,
    output logic [7:0]        colg
);
    import dz_pkg::*;

    dz_status_t status;
    logic       start;
    logic [2:0] load_digit;
    logic [2:0] row_idx;
    logic [7:0] red_bits;
    logic [7:0] green_bits;

    dz_regs dz_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .status     (status),
        .start      (start),
        .load_digit (load_digit)
    );

    dz_countdown #(.TICK_DIV(TICK_DIV)) dz_countdown_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .load_digit (load_digit),
        .status     (status)
    );

    dz_glyph_rom dz_glyph_rom_inst (
        .digit      (status.digit),
        .row_idx    (row_idx),
        .red_bits   (red_bits),
        .green_bits (green_bits)
    );

    dz_scan dz_scan_inst (
        .clk        (clk),
        .rst        (rst),
        .digit      (status.digit),
        .row_idx    (row_idx),
        .red_bits   (red_bits),
        .green_bits (green_bits),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

endmodule

//--- tb/tb_dz_show.sv
`timescale 1ns/1ps

module tb_dz_show;
    import dz_pkg::*;

    localparam int TICK_DIV = 40;
    localparam int HS_LIMIT = 20;
    localparam int WATCHDOG_CYCLES = 6 * TICK_DIV * 8 + 2000;

    logic       clk = 1'b0;
    logic       rst;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    // expected display state
    logic [2:0] m_digit = 3'd0;
    logic [2:0] m_prev = 3'd0;
    logic [2:0] m_load = 3'd0;
    logic       m_run = 1'b0;
    int         m_tick = 0;
    int         m_win = 0;     // clocks where the old digit is still accepted
    int         scan_row = -1; // last scanned row, -1 before the first scan
    int         cyc = 0;
    int         n_red = 0;
    int         n_yellow = 0;
    int         n_green = 0;

    dz_show_top #(.TICK_DIV(TICK_DIV)) dz_show_top_inst (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

    initial
        forever #4 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic fail_stop(input string why);
        begin
            $display("%s", why);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // returns {red, green} columns for one row of a digit
    function automatic logic [15:0] glyph_ref(input logic [2:0] d, input logic [2:0] r);
        logic [63:0] g;
        logic [7:0]  p;
        begin
            case (d)
                3'd0:    g = 64'h3C42_4242_4242_3C00;
                3'd1:    g = 64'h1818_3818_1818_7E00;
                3'd2:    g = 64'h3C66_060C_3060_7E00;
                3'd3:    g = 64'h3C66_061C_0666_3C00;
                3'd4:    g = 64'h0C1C_2C4C_7E0C_0C00;
                3'd5:    g = 64'h7E60_7C06_0666_3C00;
                default: g = 64'd0;
            endcase
            p = g[8 * (7 - int'(r)) +: 8];   // row 0 is the top byte
            // red for 2..5, green for 0..3, both means yellow
            return {(d >= 3'd2) ? p : 8'h00, (d <= 3'd3) ? p : 8'h00};
        end
    endfunction

    // countdown model, stepped on accepted writes
    always @(posedge clk)
    begin : ref_model
        logic [2:0] nxt;
        logic       wr_accept;
        nxt = m_digit;
        wr_accept = axil_rsp.awready && axil_req.awvalid && axil_req.wvalid;
        if (rst)
        begin
            nxt = 3'd0;
            m_load <= 3'd0;
            m_run  <= 1'b0;
            m_tick <= 0;
        end
        else if (wr_accept && axil_req.awaddr == dz_addr_ctrl && axil_req.wdata[0])
        begin
            nxt = m_load;
            m_run  <= (m_load != 3'd0);
            m_tick <= 0;
        end
        else if (m_run)
        begin
            if (m_tick == TICK_DIV - 1)
            begin
                nxt = m_digit - 3'd1;
                m_run  <= (m_digit != 3'd1);
                m_tick <= 0;
            end
            else
                m_tick <= m_tick + 1;
        end
        if (!rst && wr_accept && axil_req.awaddr == dz_addr_load && axil_req.wdata <= 32'd5)
            m_load <= axil_req.wdata[2:0];
        if (nxt != m_digit)
        begin
            m_prev <= m_digit;
            m_win  <= 3;
        end
        else if (m_win != 0)
            m_win <= m_win - 1;
        m_digit <= nxt;
    end

    always @(negedge clk)
    begin : display_check
        int          r;
        logic [15:0] seen;
        logic        ok;
        if (rst)
            scan_row = -1;
        else if ($countones(~row) == 1)
        begin
            r = 0;
            for (int i = 0; i < 8; i++)
                if (!row[i])
                    r = i;
            // rows step 0..7 and wrap
            assert (r == (scan_row + 1) % 8)
            else
                fail_stop($sformatf("FAIL row: got %h expected %h", row,
                    ~(8'd1 << ((scan_row + 1) % 8))));
            scan_row = r;
            seen = {colr, colg};
            ok = (seen == glyph_ref(m_digit, 3'(r)))
                || (m_win != 0 && seen == glyph_ref(m_prev, 3'(r)));
            assert (ok)
            else
                fail_stop($sformatf("FAIL colr/colg row %0d: got %h/%h expected %h for digit %0d",
                    r, colr, colg, glyph_ref(m_digit, 3'(r)), m_digit));
            if (m_win == 0)
            begin
                if (m_digit >= 3'd4)
                    n_red++;
                else if (m_digit >= 3'd2)
                    n_yellow++;
                else
                    n_green++;
            end
        end
        else
        begin
            assert (scan_row < 0 && row == 8'hff)
            else
                fail_stop($sformatf("FAIL row: got %h with no single active row", row));
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        begin
            @(posedge clk);
            axil_req.awvalid <= 1'b1;
            axil_req.awaddr  <= addr;
            axil_req.wvalid  <= 1'b1;
            axil_req.wdata   <= data;
            axil_req.wstrb   <= 4'hf;
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
            end
            while (!axil_rsp.awready && n < HS_LIMIT);
            assert (axil_rsp.awready && axil_rsp.wready)
            else
                fail_stop($sformatf("write to offset %h was never accepted", addr));
            axil_req.awvalid <= 1'b0;
            axil_req.wvalid  <= 1'b0;
            repeat ($urandom_range(0, 3)) @(posedge clk);
            axil_req.bready <= 1'b1;
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
            end
            while (!axil_rsp.bvalid && n < HS_LIMIT);
            assert (axil_rsp.bvalid)
            else
                fail_stop("write response never arrived");
            resp = axil_rsp.bresp;
            axil_req.bready <= 1'b0;
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        begin
            @(posedge clk);
            axil_req.arvalid <= 1'b1;
            axil_req.araddr  <= addr;
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
            end
            while (!axil_rsp.arready && n < HS_LIMIT);
            assert (axil_rsp.arready)
            else
                fail_stop($sformatf("read of offset %h was never accepted", addr));
            axil_req.arvalid <= 1'b0;
            repeat ($urandom_range(0, 3)) @(posedge clk);
            axil_req.rready <= 1'b1;
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
            end
            while (!axil_rsp.rvalid && n < HS_LIMIT);
            assert (axil_rsp.rvalid)
            else
                fail_stop("read data never arrived");
            data = axil_rsp.rdata;
            resp = axil_rsp.rresp;
            axil_req.rready <= 1'b0;
        end
    endtask

    task automatic write_ok(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        begin
            write_reg(addr, data, resp);
            assert (resp == 2'b00)
            else
                fail_stop($sformatf("FAIL bresp: got %h expected 0", resp));
        end
    endtask

    task automatic check_status(input logic [2:0] digit, input logic running, input logic done);
        logic [31:0] data;
        logic [1:0]  resp;
        begin
            read_reg(dz_addr_status, data, resp);
            assert (resp == 2'b00 && data[5:0] == {done, running, 1'b0, digit})
            else
                fail_stop($sformatf("FAIL status: got %h rresp %h expected %h", data, resp,
                    {26'd0, done, running, 1'b0, digit}));
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_stop($sformatf("timeout: tests did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin : main
        logic [31:0] data;
        logic [1:0]  resp;
        logic [2:0]  last;
        int          t0;
        int          r0;
        void'($urandom(32'h3e578d72));
        rst      <= 1'b1;
        axil_req <= '0;
        repeat (3)
        begin
            @(negedge clk);
            assert (row == 8'hff && colr == 8'h00 && colg == 8'h00)
            else
                fail_stop($sformatf("FAIL row/colr/colg in reset: %h %h %h", row, colr, colg));
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);
        assert (n_green > 0)
        else
            fail_stop("display never showed digit 0 after reset");

        // count from 5 down to 0
        write_ok(dz_addr_load, 32'd5);
        write_ok(dz_addr_ctrl, 32'd1);
        t0 = cyc;
        r0 = n_red;
        check_status(3'd5, 1'b1, 1'b0);
        repeat (16) @(posedge clk);
        assert (n_red > r0 + 15)
        else
            fail_stop("digit 5 was not scanned in red");
        last = 3'd5;
        do
        begin
            repeat ($urandom_range(5, 15)) @(posedge clk);
            read_reg(dz_addr_status, data, resp);
            assert (data[2:0] <= last)
            else
                fail_stop($sformatf("FAIL status digit rose: %h after %h", data[2:0], last));
            last = data[2:0];
        end
        while (!data[5]);
        assert (cyc - t0 >= 5 * TICK_DIV - 8 && cyc - t0 <= 5 * TICK_DIV + 40)
        else
            fail_stop($sformatf("countdown took %0d cycles", cyc - t0));
        check_status(3'd0, 1'b0, 1'b1);
        assert (n_red > 0 && n_yellow > 0 && n_green > 0)
        else
            fail_stop("not all three colours were displayed");

        // refused load keeps the old value
        write_reg(dz_addr_load, 32'd7, resp);
        assert (resp == axil_slverr)
        else
            fail_stop($sformatf("FAIL bresp: got %h expected %h", resp, axil_slverr));
        write_ok(dz_addr_ctrl, 32'd1);
        check_status(3'd5, 1'b1, 1'b0);
        read_reg(4'hc, data, resp);
        assert (resp == axil_slverr)
        else
            fail_stop($sformatf("FAIL rresp: got %h expected %h", resp, axil_slverr));

        // restart in the middle of a count
        write_ok(dz_addr_load, 32'd3);
        write_ok(dz_addr_ctrl, 32'd1);
        check_status(3'd3, 1'b1, 1'b0);
        repeat (TICK_DIV / 4) @(posedge clk);
        write_ok(dz_addr_load, 32'd2);
        write_ok(dz_addr_ctrl, 32'd1);
        check_status(3'd2, 1'b1, 1'b0);
        repeat (24) @(posedge clk);

        $display("Verification passed");
        $finish;
    end

endmodule
